// File: verilog.f
+incdir+.
core_isa_pkg.sv
core_bus_pkg.sv
fetch_if.sv
dcr_regs.sv
core_fetch.sv
core_execute.sv
core_perf.sv
simple_core.sv
tb_simple_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_simple_core
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert
PASS_MSG  := *** TEST PASSED ***

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
HEADERS := $(wildcard *.svh)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

// File: tb_simple_core.sv
/*
 * Testbench for the core top level
 *   Instruction and data memory models with optional random stalls
 *   ISA reference model predicting commits, data memory and counters
 *   Directed tests for arithmetic, load/store, branches, stalls and restart
 */
`include "core_cfg.svh"

module tb_simple_core import core_isa_pkg::*, core_bus_pkg::*; ();

    // The longest test runs for about 200 cycles with stalls enabled
    localparam int MAX_CYCLES = 2000;

    logic                      clk = 1'b0;
    logic                      reset;
    logic                      dcr_wr_valid;
    dcr_addr_t                 dcr_wr_addr;
    logic [`XLEN-1:0]          dcr_wr_data;
    logic                      imem_req_valid;
    logic                      imem_req_ready;
    logic [`XLEN-1:0]          imem_req_addr;
    logic                      imem_rsp_valid;
    logic                      imem_rsp_ready;
    logic [`XLEN-1:0]          imem_rsp_data;
    logic                      dmem_req_valid;
    logic                      dmem_req_ready;
    mem_req_t                  dmem_req_data;
    logic                      dmem_rsp_valid;
    logic                      dmem_rsp_ready;
    logic [`XLEN-1:0]          dmem_rsp_data;
    logic                      commit_valid;
    logic [2:0]                commit_rd;
    logic [`XLEN-1:0]          commit_value;
    logic                      busy;
    logic [`PERF_CTR_BITS-1:0] perf_ifetches;
    logic [`PERF_CTR_BITS-1:0] perf_loads;
    logic [`PERF_CTR_BITS-1:0] perf_stores;
    logic [`PERF_CTR_BITS-1:0] perf_instret;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    logic [31:0] ref_dmem [256];
    logic [31:0] ref_regs [8];
    logic [34:0] exp_commits [$];
    int          exp_fetches;
    int          exp_loads;
    int          exp_stores;
    int          exp_instret;
    string       test_name;
    int          test_errors;
    int          total_errors;
    int          tests_run;
    int          tests_failed;
    int          cycles;
    bit          stall;
    logic [7:0]  prog_ptr;
    logic        i_pend;
    logic [1:0]  i_cnt;
    logic [31:0] i_addr;
    logic        d_pend;
    logic [1:0]  d_cnt;
    logic [7:0]  d_addr;

    simple_core simple_core_inst (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles in test %s", cycles, test_name);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    function automatic logic [1:0] rsp_delay();
        return stall ? 2'($urandom_range(1, 3)) : 2'd1;
    endfunction

    task automatic fill_dmem();
        for (int a = 0; a < 256; a++) begin
            dmem[a[7:0]] = {24'hda7a00, a[7:0]};
        end
    endtask

    // Instruction memory model that answers each accepted request once
    initial begin
        imem_req_ready <= 1'b0;
        imem_rsp_valid <= 1'b0;
        imem_rsp_data  <= '0;
        i_pend = 1'b0;
        forever begin
            @(posedge clk);
            if (reset) begin
                imem_req_ready <= 1'b0;
                imem_rsp_valid <= 1'b0;
                i_pend = 1'b0;
            end else begin
                imem_req_ready <= stall ? ($urandom_range(0, 3) != 0) : 1'b1;
                if (imem_rsp_valid && imem_rsp_ready) begin
                    imem_rsp_valid <= 1'b0;
                end
                if (imem_req_valid && imem_req_ready) begin
                    i_pend = 1'b1;
                    i_cnt  = rsp_delay();
                    i_addr = imem_req_addr;
                end else if (i_pend) begin
                    if (i_cnt <= 2'd1) begin
                        imem_rsp_valid <= 1'b1;
                        imem_rsp_data  <= imem[i_addr[9:2]];
                        i_pend = 1'b0;
                    end else begin
                        i_cnt = i_cnt - 2'd1;
                    end
                end
            end
        end
    end

    // Data memory model where stores complete on the request and loads answer later
    initial begin
        dmem_req_ready <= 1'b0;
        dmem_rsp_valid <= 1'b0;
        dmem_rsp_data  <= '0;
        d_pend = 1'b0;
        fill_dmem();
        forever begin
            @(posedge clk);
            if (reset) begin
                dmem_req_ready <= 1'b0;
                dmem_rsp_valid <= 1'b0;
                d_pend = 1'b0;
            end else begin
                dmem_req_ready <= stall ? ($urandom_range(0, 3) != 0) : 1'b1;
                if (dmem_rsp_valid && dmem_rsp_ready) begin
                    dmem_rsp_valid <= 1'b0;
                end
                if (dmem_req_valid && dmem_req_ready) begin
                    if (dmem_req_data.rw) begin
                        dmem[dmem_req_data.addr[7:0]] = dmem_req_data.wdata;
                    end else begin
                        d_pend = 1'b1;
                        d_cnt  = rsp_delay();
                        d_addr = dmem_req_data.addr[7:0];
                    end
                end else if (d_pend) begin
                    if (d_cnt <= 2'd1) begin
                        dmem_rsp_valid <= 1'b1;
                        dmem_rsp_data  <= dmem[d_addr];
                        d_pend = 1'b0;
                    end else begin
                        d_cnt = d_cnt - 2'd1;
                    end
                end
            end
        end
    end

    task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("MISMATCH %s %s: expected %h, actual %h", test_name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_commit();
        logic [34:0] e;
        assert (exp_commits.size() != 0) else begin
            $display("%s: commit to r%0d when no more commits were predicted",
                     test_name, commit_rd);
            test_errors++;
        end
        if (exp_commits.size() != 0) begin
            e = exp_commits.pop_front();
            check_value("commit rd", 32'(e[34:32]), 32'(commit_rd));
            check_value("commit value", e[31:0], commit_value);
        end
    endtask

    always @(posedge clk) begin
        if (!reset && commit_valid) begin
            check_commit();
        end
    end

    function automatic logic [31:0] enc_r(opcode_t op, int rd, int rs1, int rs2);
        return {op, 3'(rd), 3'(rs1), 3'(rs2), 19'd0};
    endfunction

    function automatic logic [31:0] enc_i(opcode_t op, int rd, int rs1, int imm);
        return {op, 3'(rd), 3'(rs1), 6'd0, 16'(imm)};
    endfunction

    task automatic org(input logic [31:0] pc);
        prog_ptr = pc[9:2];
    endtask

    task automatic emit(input logic [31:0] w);
        imem[prog_ptr] = w;
        prog_ptr = prog_ptr + 8'd1;
    endtask

    task automatic expect_commit(input logic [2:0] rd, input logic [31:0] val);
        exp_commits.push_back({rd, val});
        if (rd != 3'd0) begin
            ref_regs[rd] = val;
        end
    endtask

    // Runs the program on the ISA rules and records everything the DUT should do
    task automatic predict(input logic [31:0] pc0, input logic [31:0] base);
        logic [31:0] pc;
        logic [31:0] ins;
        logic [31:0] imm;
        logic [31:0] a;
        logic [31:0] addr;
        logic [2:0]  rd;
        bit          done;
        pc = pc0;
        done = 1'b0;
        ref_dmem = dmem;
        exp_commits.delete();
        exp_fetches = 0;
        exp_loads = 0;
        exp_stores = 0;
        for (int n = 0; n < 500 && !done; n++) begin
            ins  = imem[pc[9:2]];
            rd   = ins[27:25];
            a    = ref_regs[ins[24:22]];
            imm  = {{16{ins[15]}}, ins[15:0]};
            addr = base + a + imm;
            exp_fetches++;
            pc = pc + 32'd4;
            case (ins[31:28])
                OP_ADD:  expect_commit(rd, a + ref_regs[ins[21:19]]);
                OP_SUB:  expect_commit(rd, a - ref_regs[ins[21:19]]);
                OP_ADDI: expect_commit(rd, a + imm);
                OP_LW: begin
                    expect_commit(rd, ref_dmem[addr[7:0]]);
                    exp_loads++;
                end
                OP_SW: begin
                    ref_dmem[addr[7:0]] = ref_regs[rd];
                    exp_stores++;
                end
                OP_BNE: begin
                    if (ref_regs[rd] != a) begin
                        pc = pc + (imm << 2);
                    end
                end
                // HALT ends the run
                default: done = 1'b1;
            endcase
        end
        exp_instret = exp_commits.size();
    endtask

    task automatic dcr_write(input dcr_addr_t addr, input logic [31:0] data);
        @(posedge clk);
        dcr_wr_valid <= 1'b1;
        dcr_wr_addr  <= addr;
        dcr_wr_data  <= data;
        @(posedge clk);
        dcr_wr_valid <= 1'b0;
    endtask

    task automatic launch_program(input logic [31:0] pc0, input logic [31:0] base);
        predict(pc0, base);
        dcr_write(`DCR_STARTUP_PC, pc0);
        dcr_write(`DCR_DATA_BASE, base);
        dcr_write(`DCR_START, 32'd0);
        do @(posedge clk); while (!busy);
    endtask

    task automatic check_run();
        while (busy) @(posedge clk);
        assert (exp_commits.size() == 0) else begin
            $display("%s: %0d predicted commits never happened", test_name, exp_commits.size());
            test_errors++;
        end
        check_value("perf_ifetches", exp_fetches, perf_ifetches);
        check_value("perf_loads", exp_loads, perf_loads);
        check_value("perf_stores", exp_stores, perf_stores);
        check_value("perf_instret", exp_instret, perf_instret);
        for (int a = 0; a < 256; a++) begin
            check_value($sformatf("dmem[%02h]", a), ref_dmem[a[7:0]], dmem[a[7:0]]);
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        $display("%-14s %s, %0d errors", test_name, test_errors == 0 ? "ok" : "failed",
                 test_errors);
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        total_errors += test_errors;
    endtask

    task automatic test_arith();
        begin_test("arith");
        org(32'h0);
        emit(enc_i(OP_ADDI, 1, 0, 5));
        emit(enc_i(OP_ADDI, 2, 0, -3));
        emit(enc_r(OP_ADD, 3, 1, 2));
        emit(enc_r(OP_SUB, 4, 1, 2));
        emit(enc_i(OP_ADDI, 0, 1, 7));
        emit(enc_r(OP_ADD, 5, 0, 1));
        emit(enc_r(OP_SUB, 6, 0, 4));
        emit(enc_i(OP_HALT, 0, 0, 0));
        launch_program(32'h0, 32'h0);
        check_run();
        end_test();
    endtask

    // Also reused by the stall test
    task automatic load_store_program();
        org(32'h40);
        emit(enc_i(OP_ADDI, 1, 0, 32'h1234));
        emit(enc_i(OP_ADDI, 2, 0, 3));
        emit(enc_i(OP_SW, 1, 2, 4));
        emit(enc_i(OP_ADDI, 3, 0, -100));
        emit(enc_i(OP_SW, 3, 0, 2));
        emit(enc_i(OP_LW, 4, 2, 4));
        emit(enc_i(OP_LW, 5, 0, 2));
        emit(enc_i(OP_LW, 6, 0, 9));
        emit(enc_r(OP_ADD, 7, 4, 5));
        emit(enc_i(OP_HALT, 0, 0, 0));
    endtask

    task automatic test_load_store();
        begin_test("load_store");
        load_store_program();
        launch_program(32'h40, 32'h80);
        check_run();
        check_value("stored word", 32'h1234, dmem[8'h87]);
        end_test();
    endtask

    task automatic test_branch_loop();
        begin_test("branch_loop");
        org(32'h100);
        emit(enc_i(OP_ADDI, 1, 0, 4));
        emit(enc_i(OP_ADDI, 2, 0, 0));
        emit(enc_r(OP_ADD, 2, 2, 1));
        emit(enc_i(OP_ADDI, 1, 1, -1));
        emit(enc_i(OP_BNE, 1, 0, -3));
        emit(enc_i(OP_HALT, 0, 0, 0));
        launch_program(32'h100, 32'h0);
        check_run();
        repeat (10) begin
            @(posedge clk);
            assert (!imem_req_valid) else begin
                $display("%s: instruction fetch requested after halt", test_name);
                test_errors++;
            end
        end
        end_test();
    endtask

    task automatic test_backpressure();
        begin_test("backpressure");
        stall = 1'b1;
        // Fresh contents so the stores of this run must really land
        fill_dmem();
        load_store_program();
        launch_program(32'h40, 32'h80);
        check_run();
        stall = 1'b0;
        end_test();
    endtask

    task automatic test_restart();
        begin_test("restart");
        org(32'h200);
        emit(enc_i(OP_ADDI, 1, 0, 6));
        emit(enc_i(OP_ADDI, 1, 1, -1));
        emit(enc_i(OP_SW, 1, 1, 16));
        emit(enc_i(OP_BNE, 1, 0, -3));
        emit(enc_i(OP_LW, 3, 0, 19));
        emit(enc_i(OP_HALT, 0, 0, 0));
        launch_program(32'h200, 32'h20);
        // The core is running, so this START must have no effect
        dcr_write(`DCR_START, 32'd0);
        check_run();
        end_test();
    endtask

    initial begin
        void'($urandom(94));
        reset        <= 1'b1;
        dcr_wr_valid <= 1'b0;
        dcr_wr_addr  <= '0;
        dcr_wr_data  <= '0;
        stall = 1'b0;
        ref_regs = '{default: '0};
        for (int a = 0; a < 256; a++) begin
            imem[a[7:0]] = {24'd0, a[7:0]};
        end
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        test_arith();
        test_load_store();
        test_branch_loop();
        test_backpressure();
        test_restart();
        $display("Tests run %0d, tests failed %0d, failed checks %0d",
                 tests_run, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: simple_core.sv
/*
 * Core top level
 *   Configuration registers, fetch, execute and performance counters
 *   Memory, DCR and commit trace on plain ports
 */
`include "core_cfg.svh"

module simple_core import core_bus_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      dcr_wr_valid,
    input  dcr_addr_t                 dcr_wr_addr,
    input  logic [`XLEN-1:0]          dcr_wr_data,
    output logic                      imem_req_valid,
    input  logic                      imem_req_ready,
    output logic [`XLEN-1:0]          imem_req_addr,
    input  logic                      imem_rsp_valid,
    output logic                      imem_rsp_ready,
    input  logic [`XLEN-1:0]          imem_rsp_data,
    output logic                      dmem_req_valid,
    input  logic                      dmem_req_ready,
    output mem_req_t                  dmem_req_data,
    input  logic                      dmem_rsp_valid,
    output logic                      dmem_rsp_ready,
    input  logic [`XLEN-1:0]          dmem_rsp_data,
    output logic                      commit_valid,
    output logic [2:0]                commit_rd,
    output logic [`XLEN-1:0]          commit_value,
    output logic                      busy,
    output logic [`PERF_CTR_BITS-1:0] perf_ifetches,
    output logic [`PERF_CTR_BITS-1:0] perf_loads,
    output logic [`PERF_CTR_BITS-1:0] perf_stores,
    output logic [`PERF_CTR_BITS-1:0] perf_instret
);

    logic [`XLEN-1:0] startup_pc;
    logic [`XLEN-1:0] data_base;
    logic             start;
    logic             redirect_valid;
    logic [`XLEN-1:0] redirect_pc;
    logic             halted;

    fetch_if fetch_bus ();

    dcr_regs dcr_regs_inst (
        .clk          (clk),
        .reset        (reset),
        .dcr_wr_valid (dcr_wr_valid),
        .dcr_wr_addr  (dcr_wr_addr),
        .dcr_wr_data  (dcr_wr_data),
        .busy         (busy),
        .startup_pc   (startup_pc),
        .data_base    (data_base),
        .start        (start)
    );

    core_fetch core_fetch_inst (
        .clk            (clk),
        .reset          (reset),
        .start          (start),
        .startup_pc     (startup_pc),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .halted         (halted),
        .imem_req_valid (imem_req_valid),
        .imem_req_ready (imem_req_ready),
        .imem_req_addr  (imem_req_addr),
        .imem_rsp_valid (imem_rsp_valid),
        .imem_rsp_ready (imem_rsp_ready),
        .imem_rsp_data  (imem_rsp_data),
        .fetch          (fetch_bus.producer)
    );

    core_execute core_execute_inst (
        .clk            (clk),
        .reset          (reset),
        .start          (start),
        .data_base      (data_base),
        .fetch          (fetch_bus.consumer),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .halted         (halted),
        .busy           (busy),
        .dmem_req_valid (dmem_req_valid),
        .dmem_req_ready (dmem_req_ready),
        .dmem_req_data  (dmem_req_data),
        .dmem_rsp_valid (dmem_rsp_valid),
        .dmem_rsp_ready (dmem_rsp_ready),
        .dmem_rsp_data  (dmem_rsp_data),
        .commit_valid   (commit_valid),
        .commit_rd      (commit_rd),
        .commit_value   (commit_value)
    );

    core_perf core_perf_inst (
        .clk            (clk),
        .reset          (reset),
        .start          (start),
        .imem_req_valid (imem_req_valid),
        .imem_req_ready (imem_req_ready),
        .dmem_req_valid (dmem_req_valid),
        .dmem_req_ready (dmem_req_ready),
        .dmem_req_data  (dmem_req_data),
        .commit_valid   (commit_valid),
        .perf_ifetches  (perf_ifetches),
        .perf_loads     (perf_loads),
        .perf_stores    (perf_stores),
        .perf_instret   (perf_instret)
    );

endmodule

// File: core_perf.sv
/*
 * Performance counters
 *   Instruction fetch requests
 *   Data loads and stores, split by request type
 *   Retired instructions with a result
 */
`include "core_cfg.svh"

module core_perf import core_bus_pkg::*; (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     start,
    input  logic                     imem_req_valid,
    input  logic                     imem_req_ready,
    input  logic                     dmem_req_valid,
    input  logic                     dmem_req_ready,
    input  mem_req_t                 dmem_req_data,
    input  logic                     commit_valid,
    output logic [`PERF_CTR_BITS-1:0] perf_ifetches,
    output logic [`PERF_CTR_BITS-1:0] perf_loads,
    output logic [`PERF_CTR_BITS-1:0] perf_stores,
    output logic [`PERF_CTR_BITS-1:0] perf_instret
);

    logic ifetch_fire;
    logic dmem_fire;

    assign ifetch_fire = imem_req_valid & imem_req_ready;
    assign dmem_fire   = dmem_req_valid & dmem_req_ready;

    always_ff @(posedge clk) begin
        if (reset || start) begin
            perf_ifetches <= '0;
            perf_loads    <= '0;
            perf_stores   <= '0;
            perf_instret  <= '0;
        end else begin
            perf_ifetches <= perf_ifetches + `PERF_CTR_BITS'(ifetch_fire);
            perf_loads    <= perf_loads + `PERF_CTR_BITS'(dmem_fire & ~dmem_req_data.rw);
            perf_stores   <= perf_stores + `PERF_CTR_BITS'(dmem_fire & dmem_req_data.rw);
            perf_instret  <= perf_instret + `PERF_CTR_BITS'(commit_valid);
        end
    end

endmodule

// File: core_execute.sv
/*
 * Decode, execute and commit
 *   Union-based decode of R-form and I-form words
 *   Register file with hardwired zero in r0
 *   ALU, BNE resolution and redirect
 *   Load/store sequencing on the data-memory bus
 *   Commit reporting and busy tracking
 */
`include "core_cfg.svh"

module core_execute import core_isa_pkg::*, core_bus_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  logic             start,
    input  logic [`XLEN-1:0] data_base,
    fetch_if.consumer        fetch,
    output logic             redirect_valid,
    output logic [`XLEN-1:0] redirect_pc,
    output logic             halted,
    output logic             busy,
    output logic             dmem_req_valid,
    input  logic             dmem_req_ready,
    output mem_req_t         dmem_req_data,
    input  logic             dmem_rsp_valid,
    output logic             dmem_rsp_ready,
    input  logic [`XLEN-1:0] dmem_rsp_data,
    output logic             commit_valid,
    output logic [2:0]       commit_rd,
    output logic [`XLEN-1:0] commit_value
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,
        S_WAIT
    } ex_state_t;

    ex_state_t        state;
    instr_t           ins;
    opcode_t          op;
    logic             fire;
    logic             is_rform;
    logic             is_alu;
    logic             is_mem;
    logic [2:0]       src_b_idx;
    logic [`XLEN-1:0] src_a;
    logic [`XLEN-1:0] src_b;
    logic [`XLEN-1:0] imm_ext;
    logic [`XLEN-1:0] alu_result;
    logic             load_done;
    logic [2:0]       ld_rd;
    mem_req_t         mem_req;
    logic [`XLEN-1:0] regs [`NUM_REGS];

    assign ins      = fetch.instr;
    assign op       = ins.r.opcode;
    assign fire     = fetch.valid & fetch.ready;
    assign is_rform = (op == OP_ADD) || (op == OP_SUB);
    assign is_alu   = is_rform || (op == OP_ADDI);
    assign is_mem   = (op == OP_LW) || (op == OP_SW);
    assign imm_ext  = `XLEN'($signed(ins.i.imm));

    // The second operand comes from rs2 in R-form and from rd otherwise
    assign src_b_idx = is_rform ? ins.r.rs2 : ins.i.rd;
    assign src_a     = (ins.r.rs1 == 3'd0) ? '0 : regs[ins.r.rs1];
    assign src_b     = (src_b_idx == 3'd0) ? '0 : regs[src_b_idx];

    always_comb begin
        case (op)
            OP_ADD:  alu_result = src_a + src_b;
            OP_SUB:  alu_result = src_a - src_b;
            default: alu_result = src_a + imm_ext;
        endcase
    end

    assign redirect_valid = fire && (op == OP_BNE) && (src_a != src_b);
    assign redirect_pc    = fetch.pc + `XLEN'(4) + (imm_ext << 2);
    assign halted         = fire && (op == OP_HALT);

    // Only one instruction is in flight, so a memory access stalls the handoff
    assign fetch.ready    = (state == S_IDLE);
    assign dmem_req_valid = (state == S_REQ);
    assign dmem_req_data  = mem_req;
    assign dmem_rsp_ready = (state == S_WAIT);
    assign load_done      = dmem_rsp_valid & dmem_rsp_ready;

    assign commit_valid = (fire & is_alu) | load_done;
    assign commit_rd    = load_done ? ld_rd : ins.r.rd;
    assign commit_value = load_done ? dmem_rsp_data : alu_result;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_IDLE;
            busy  <= 1'b0;
        end else begin
            if (start) begin
                busy <= 1'b1;
            end else if (halted) begin
                busy <= 1'b0;
            end
            case (state)
                S_IDLE: if (fire && is_mem) state <= S_REQ;
                S_REQ:  if (dmem_req_ready) state <= mem_req.rw ? S_IDLE : S_WAIT;
                S_WAIT: if (dmem_rsp_valid) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fire && is_mem) begin
            mem_req.rw    <= (op == OP_SW);
            mem_req.addr  <= data_base + src_a + imm_ext;
            mem_req.wdata <= src_b;
            ld_rd         <= ins.i.rd;
        end
        // r0 stays zero but its commit is still reported
        if (commit_valid && commit_rd != 3'd0) begin
            regs[commit_rd] <= commit_value;
        end
    end

    assert property (@(posedge clk) disable iff (reset) fire |-> op_legal(op));

    assert property (@(posedge clk) disable iff (reset) dmem_rsp_valid |-> state == S_WAIT);

endmodule

// File: core_fetch.sv
/*
 * Instruction fetch
 *   PC register with sequential and branch redirect update
 *   Single outstanding instruction-memory request
 *   Holding buffer for the returned word until execute accepts it
 */
`include "core_cfg.svh"

module core_fetch (
    input  logic             clk,
    input  logic             reset,
    input  logic             start,
    input  logic [`XLEN-1:0] startup_pc,
    input  logic             redirect_valid,
    input  logic [`XLEN-1:0] redirect_pc,
    input  logic             halted,
    output logic             imem_req_valid,
    input  logic             imem_req_ready,
    output logic [`XLEN-1:0] imem_req_addr,
    input  logic             imem_rsp_valid,
    output logic             imem_rsp_ready,
    input  logic [`XLEN-1:0] imem_rsp_data,
    fetch_if.producer        fetch
);

    logic [`XLEN-1:0] pc;
    logic             running;
    logic             outstanding;
    logic             fetch_fire;

    // A new request goes out only when nothing is in flight or buffered
    assign imem_req_valid = running & ~outstanding & ~fetch.valid;
    assign imem_req_addr  = pc;
    assign imem_rsp_ready = outstanding;
    assign fetch.pc       = pc;
    assign fetch_fire     = fetch.valid & fetch.ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            running     <= 1'b0;
            outstanding <= 1'b0;
            fetch.valid <= 1'b0;
        end else if (start) begin
            running     <= 1'b1;
            outstanding <= 1'b0;
            fetch.valid <= 1'b0;
        end else begin
            if (imem_req_valid && imem_req_ready) begin
                outstanding <= 1'b1;
            end
            if (imem_rsp_valid && imem_rsp_ready) begin
                outstanding <= 1'b0;
                fetch.valid <= 1'b1;
            end
            if (fetch_fire) begin
                fetch.valid <= 1'b0;
                if (halted) begin
                    running <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            pc <= startup_pc;
        end else if (fetch_fire) begin
            pc <= redirect_valid ? redirect_pc : pc + `XLEN'(4);
        end
        if (imem_rsp_valid && imem_rsp_ready) begin
            fetch.instr <= imem_rsp_data;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        imem_req_valid && !imem_req_ready |=> imem_req_valid && $stable(imem_req_addr));

    assert property (@(posedge clk) disable iff (reset) imem_rsp_valid |-> outstanding);

endmodule

// File: dcr_regs.sv
/*
 * Device configuration registers
 *   Startup PC and data base address
 *   One-cycle start pulse, accepted only while idle
 */
`include "core_cfg.svh"

module dcr_regs import core_bus_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  logic             dcr_wr_valid,
    input  dcr_addr_t        dcr_wr_addr,
    input  logic [`XLEN-1:0] dcr_wr_data,
    input  logic             busy,
    output logic [`XLEN-1:0] startup_pc,
    output logic [`XLEN-1:0] data_base,
    output logic             start
);

    always_ff @(posedge clk) begin
        if (reset) begin
            startup_pc <= '0;
            data_base  <= '0;
            start      <= 1'b0;
        end else begin
            start <= 1'b0;
            if (dcr_wr_valid) begin
                case (dcr_wr_addr)
                    `DCR_STARTUP_PC: startup_pc <= dcr_wr_data;
                    `DCR_DATA_BASE:  data_base  <= dcr_wr_data;
                    // Busy rises one cycle after the pulse, so a pulse in flight also blocks
                    `DCR_START:      start <= ~busy & ~start;
                    default: ;
                endcase
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset) start |-> !busy);

endmodule

// File: fetch_if.sv
/*
 * Fetch to execute handoff
 *   Fetched instruction word with its PC
 *   valid/ready handshake, producer and consumer views
 */
`include "core_cfg.svh"

interface fetch_if import core_isa_pkg::*; ();

    logic             valid;
    logic             ready;
    logic [`XLEN-1:0] pc;
    instr_t           instr;

    modport producer (
        output valid,
        output pc,
        output instr,
        input  ready
    );

    modport consumer (
        input  valid,
        input  pc,
        input  instr,
        output ready
    );

endinterface

// File: core_bus_pkg.sv
/*
 * Bus payload definitions
 *   Data-memory request payload
 *   DCR address type
 */
`include "core_cfg.svh"

package core_bus_pkg;

    // rw is high for a store; loads ignore wdata
    typedef struct packed {
        logic              rw;
        logic [`XLEN-1:0]  addr;
        logic [`XLEN-1:0]  wdata;
    } mem_req_t;

    typedef logic [7:0] dcr_addr_t;

endpackage

// File: core_isa_pkg.sv
/*
 * Instruction set definitions
 *   Opcode encoding and legality check
 *   R-form and I-form instruction layouts
 *   Union viewing one instruction word in either form
 */
package core_isa_pkg;

    typedef enum logic [3:0] {
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_ADDI = 4'd3,
        OP_LW   = 4'd4,
        OP_SW   = 4'd5,
        OP_BNE  = 4'd6,
        OP_HALT = 4'd15
    } opcode_t;

    typedef struct packed {
        opcode_t     opcode;
        logic [2:0]  rd;
        logic [2:0]  rs1;
        logic [2:0]  rs2;
        logic [18:0] unused;
    } instr_r_t;

    // SW stores rd and BNE compares rd with rs1
    typedef struct packed {
        opcode_t            opcode;
        logic [2:0]         rd;
        logic [2:0]         rs1;
        logic [5:0]         unused;
        logic signed [15:0] imm;
    } instr_i_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_t;

    function automatic logic op_legal(logic [3:0] op);
        case (op)
            OP_ADD, OP_SUB, OP_ADDI, OP_LW, OP_SW, OP_BNE, OP_HALT: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

endpackage

// File: core_cfg.svh
/*
 * Core configuration macros
 *   Word width, register count and counter width
 *   Device configuration register addresses
 */
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

`define XLEN 32

`define NUM_REGS 8

`define PERF_CTR_BITS 32

// DCR addresses written by the host before START
`define DCR_STARTUP_PC 8'd0
`define DCR_DATA_BASE 8'd1
`define DCR_START 8'd2

`endif
